/* estimatorPkg.sv */
package estimatorPkg;

    //////////////////////////////
    // word formats
    //////////////////////////////

    // Q8.23 data word
    localparam int wordWidth  = 32;
    localparam int intBits    = 8;
    localparam int fracBits   = 23;

    // integer bits of the reported estimates (Q5.26)
    localparam int outIntBits = 5;

    // product and sum word, 46 fraction bits
    localparam int wideWidth  = 2 * wordWidth;

    typedef logic signed [wordWidth-1:0] qWord_t;

    // saturation limits of a single word
    localparam qWord_t qMax = {1'b0, {(wordWidth-1){1'b1}}};
    localparam qWord_t qMin = {1'b1, {(wordWidth-1){1'b0}}};

    // full view for the adders
    // field view for narrowing back to Q8.23
    // spare and guard together are the nine bits above the kept field
    typedef union packed {
        logic signed [wideWidth-1:0] full;
        struct packed {
            logic                 sign;
            logic                 spare;
            logic [intBits-1:0]   guard;
            logic [wordWidth-2:0] kept;
            logic [fracBits-1:0]  dropped;
        } field;
    } wideWord_u;

    //////////////////////////////
    // saturating arithmetic
    //////////////////////////////

    // full signed product, Q16.46
    function automatic wideWord_u mulWide(qWord_t a, qWord_t b);
        wideWord_u p;
        p.full = wideWidth'(a) * wideWidth'(b);
        return p;
    endfunction

    // wide add, clamps on overflow
    function automatic wideWord_u addSat(wideWord_u a, wideWord_u b);
        wideWord_u s;
        s.full = a.full + b.full;
        // same operand signs but the sum flipped
        if ((a.full[wideWidth-1] == b.full[wideWidth-1]) &&
            (s.full[wideWidth-1] != a.full[wideWidth-1])) begin
            s.full = a.full[wideWidth-1] ? {1'b1, {(wideWidth-1){1'b0}}}
                                         : {1'b0, {(wideWidth-1){1'b1}}};
        end
        return s;
    endfunction

    // single word subtract, clamps on overflow
    function automatic qWord_t subSat(qWord_t a, qWord_t b);
        qWord_t d;
        d = a - b;
        // only differing signs can overflow here
        if ((a[wordWidth-1] != b[wordWidth-1]) && (d[wordWidth-1] != a[wordWidth-1])) begin
            d = a[wordWidth-1] ? qMin : qMax;
        end
        return d;
    endfunction

    // Q8.23 into the wide format
    // sign extend on top, zero fraction below
    function automatic wideWord_u widen(qWord_t q);
        wideWord_u w;
        w.full = {{(wideWidth-wordWidth-fracBits){q[wordWidth-1]}}, q, {fracBits{1'b0}}};
        return w;
    endfunction

    // wide word back to Q8.23
    // the lower fraction bits are simply truncated
    function automatic qWord_t narrow(wideWord_u w);
        qWord_t r;
        if ({w.field.spare, w.field.guard} == {(intBits+1){w.field.sign}}) begin
            r = {w.field.sign, w.field.kept};
        end else begin
            // magnitude does not fit, clamp by sign
            r = w.field.sign ? qMin : qMax;
        end
        return r;
    endfunction

endpackage

/* predictionError.sv */
`timescale 1ns/10ps

module predictionError
    import estimatorPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   req,
    input  logic   ack,
    input  qWord_t y,
    input  qWord_t v,
    input  qWord_t thetaA,
    input  qWord_t thetaB,
    output qWord_t err,
    output qWord_t sample,
    output logic   errValid
);

    // one sample in flight, held until ack
    logic       busy;
    logic       accept;
    // one bit per stage, product through prediction
    logic [3:0] validPipe;

    // captured measurement
    qWord_t     yCap;

    // pipeline payload
    wideWord_u  productWide;
    wideWord_u  offsetWide;
    wideWord_u  sumWide;
    qWord_t     prediction;

    //////////////////////////////
    // request acceptance
    //////////////////////////////

    // new sample only when idle and the last ack is gone
    assign accept = req && !ack && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            validPipe <= '0;
            errValid  <= 1'b0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
            end else if (ack) begin
                // result delivered, ready for the next request
                busy <= 1'b0;
            end
            validPipe <= {validPipe[2:0], accept};
            // pulse once the error register is loaded
            errValid  <= validPipe[3];
        end
    end

    //////////////////////////////
    // prediction and error
    //////////////////////////////

    always_ff @(posedge clk) begin
        // y and v are only sampled on the accept edge
        if (accept) begin
            yCap   <= y;
            sample <= v;
        end
        // stage 1
        // theta1 times regressor, theta2 aligned to 46 fraction bits
        productWide <= mulWide(thetaA, sample);
        offsetWide  <= widen(thetaB);
        // stage 2
        sumWide     <= addSat(productWide, offsetWide);
        // stage 3
        // back to Q8.23
        prediction  <= narrow(sumWide);
        // stage 4
        // error held for the lanes until the next sample
        if (validPipe[3]) begin
            err <= subSat(yCap, prediction);
        end
    end

endmodule

/* thetaUpdateLane.sv */
`timescale 1ns/10ps

module thetaUpdateLane
    import estimatorPkg::*;
#(
    parameter qWord_t stepGain      = 32'h00000001,
    parameter qWord_t thetaInit     = 32'h00000000,
    parameter bit     scaleBySample = 1'b1
) (
    input  logic   clk,
    input  logic   reset,
    input  qWord_t err,
    input  qWord_t sample,
    input  logic   errValid,
    output qWord_t theta,
    output logic   thetaValid
);

    // 1.0 in Q8.23
    localparam qWord_t unity = qWord_t'(1) << fracBits;

    // stage markers, gain product through estimate load
    logic [4:0] validPipe;

    // regressor seen by this lane
    qWord_t     regressor;

    // pipeline payload
    wideWord_u  stepProd;
    qWord_t     step;
    wideWord_u  errProd;
    wideWord_u  thetaWide;
    wideWord_u  sumWide;

    // offset lane runs with a unity regressor
    // same stage count either way, step narrows back to stepGain
    assign regressor = scaleBySample ? sample : unity;

    //////////////////////////////
    // estimate and valid chain
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            validPipe <= '0;
            theta     <= thetaInit;
        end else begin
            validPipe <= {validPipe[3:0], errValid};
            // stage 5, commit the new estimate
            if (validPipe[3]) begin
                theta <= narrow(sumWide);
            end
        end
    end

    assign thetaValid = validPipe[4];

    //////////////////////////////
    // gradient step
    //////////////////////////////

    always_ff @(posedge clk) begin
        // stage 1
        // gain times regressor
        stepProd  <= mulWide(stepGain, regressor);
        // stage 2
        step      <= narrow(stepProd);
        // stage 3
        // step times error, current estimate aligned for the add
        errProd   <= mulWide(step, err);
        thetaWide <= widen(theta);
        // stage 4
        sumWide   <= addSat(errProd, thetaWide);
    end

endmodule

/* estimateOutput.sv */
`timescale 1ns/10ps

module estimateOutput
    import estimatorPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req,
    input  qWord_t     thetaA,
    input  qWord_t     thetaB,
    input  logic [1:0] thetaValid,
    output logic       ack,
    output qWord_t     theta1,
    output qWord_t     theta2
);

    // integer bits given up going from Q8.23 to Q5.26
    localparam int dropBits = intBits - outIntBits;

    logic allValid;

    // Q8.23 to Q5.26
    // sign kept, top integer bits dropped without a range check
    function automatic qWord_t toOutFormat(qWord_t q);
        return {q[wordWidth-1], q[wordWidth-2-dropBits:0], {dropBits{1'b0}}};
    endfunction

    // both lanes finish on the same edge
    assign allValid = &thetaValid;

    //////////////////////////////
    // result register and ack
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ack    <= 1'b0;
            // lanes sit at their initial estimates during reset
            theta1 <= toOutFormat(thetaA);
            theta2 <= toOutFormat(thetaB);
        end else begin
            if (allValid) begin
                ack    <= 1'b1;
                theta1 <= toOutFormat(thetaA);
                theta2 <= toOutFormat(thetaB);
            end else if (!req) begin
                // four-phase return
                ack <= 1'b0;
            end
        end
    end

endmodule

/* gradientEstimator.sv */
`timescale 1ns/10ps

module gradientEstimator
    import estimatorPkg::*;
#(
    parameter qWord_t thetaInitA = 32'h00466666,
    parameter qWord_t thetaInitB = 32'hF9800000,
    parameter qWord_t gainA      = 32'h00000001,
    parameter qWord_t gainB      = 32'h00000346
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   req,
    input  qWord_t y,
    input  qWord_t v,
    output logic   ack,
    output qWord_t theta1,
    output qWord_t theta2
);

    // error path to the lanes
    qWord_t     err;
    qWord_t     sample;
    logic       errValid;

    // lane 0 holds theta1, lane 1 holds theta2
    qWord_t     laneTheta [2];
    logic [1:0] laneValid;

    predictionError uPredictionError (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .ack      (ack),
        .y        (y),
        .v        (v),
        .thetaA   (laneTheta[0]),
        .thetaB   (laneTheta[1]),
        .err      (err),
        .sample   (sample),
        .errValid (errValid)
    );

    //////////////////////////////
    // update lanes
    //////////////////////////////

    // slope lane scales by the regressor, offset lane does not
    for (genvar lane = 0; lane < 2; lane++) begin : genLane
        thetaUpdateLane #(
            .stepGain      ((lane == 0) ? gainA : gainB),
            .thetaInit     ((lane == 0) ? thetaInitA : thetaInitB),
            .scaleBySample (lane == 0)
        ) uThetaUpdateLane (
            .clk        (clk),
            .reset      (reset),
            .err        (err),
            .sample     (sample),
            .errValid   (errValid),
            .theta      (laneTheta[lane]),
            .thetaValid (laneValid[lane])
        );
    end

    estimateOutput uEstimateOutput (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .thetaA     (laneTheta[0]),
        .thetaB     (laneTheta[1]),
        .thetaValid (laneValid),
        .ack        (ack),
        .theta1     (theta1),
        .theta2     (theta2)
    );

endmodule

/* tbEstimatorTests.svh */
`ifndef TB_ESTIMATOR_TESTS_SVH
`define TB_ESTIMATOR_TESTS_SVH

//////////////////////////////
// reference model
//////////////////////////////

// model copies of the Q8.23 estimates
qWord_t modelTheta1 = thetaInitA;
qWord_t modelTheta2 = thetaInitB;
// last error seen by the model
qWord_t modelErr    = '0;

localparam longint wideMax   = 64'sh7FFF_FFFF_FFFF_FFFF;
localparam longint wideMin   = 64'sh8000_0000_0000_0000;
localparam qWord_t wordMax   = 32'sh7FFF_FFFF;
localparam qWord_t wordMin   = 32'sh8000_0000;
// unity regressor of the offset lane
localparam qWord_t unityWord = 32'sh0080_0000;

function automatic longint fullProduct(qWord_t a, qWord_t b);
    return longint'(a) * longint'(b);
endfunction

// value times 2^23 gives 46 fraction bits
function automatic longint toWide(qWord_t q);
    return longint'(q) <<< fracBits;
endfunction

// exact sum clamped to the 64-bit range
function automatic longint clampAdd(longint a, longint b);
    logic signed [64:0] s;
    s = {a[63], a} + {b[63], b};
    if (s > wideMax) return wideMax;
    if (s < wideMin) return wideMin;
    return s[63:0];
endfunction

function automatic qWord_t clampSub(qWord_t a, qWord_t b);
    logic signed [32:0] d;
    d = {a[31], a} - {b[31], b};
    if (d > wordMax) return wordMax;
    if (d < wordMin) return wordMin;
    return d[31:0];
endfunction

// drop 23 fraction bits and clamp when the rest leaves the word range
function automatic qWord_t toWord(longint w);
    longint q;
    q = w >>> fracBits;
    if (q > longint'(wordMax)) return wordMax;
    if (q < longint'(wordMin)) return wordMin;
    return q[31:0];
endfunction

// Q5.26 view keeps the sign and loses the top integer bits
function automatic qWord_t toOut(qWord_t q);
    qWord_t s;
    s = q <<< (intBits - outIntBits);
    s[wordWidth-1] = q[wordWidth-1];
    return s;
endfunction

task automatic modelUpdate(qWord_t ySample, qWord_t vSample);
    qWord_t prediction;
    qWord_t step1;
    qWord_t step2;
    qWord_t next1;
    qWord_t next2;
    prediction  = toWord(clampAdd(fullProduct(modelTheta1, vSample), toWide(modelTheta2)));
    modelErr    = clampSub(ySample, prediction);
    step1       = toWord(fullProduct(gainA, vSample));
    step2       = toWord(fullProduct(gainB, unityWord));
    // both lanes start from the old estimates
    next1       = toWord(clampAdd(fullProduct(step1, modelErr), toWide(modelTheta1)));
    next2       = toWord(clampAdd(fullProduct(step2, modelErr), toWide(modelTheta2)));
    modelTheta1 = next1;
    modelTheta2 = next2;
endtask

task automatic checkOutputs();
    checkEstimate("theta1", theta1, toOut(modelTheta1));
    checkEstimate("theta2", theta2, toOut(modelTheta2));
endtask

//////////////////////////////
// handshake driver
//////////////////////////////

// full four-phase cycle with optional req hold and input scrambling
task automatic runSample(qWord_t yIn, qWord_t vIn, int holdCycles, bit scramble);
    int cycles;
    y      = yIn;
    v      = vIn;
    req    = 1'b1;
    cycles = 0;
    while (ack !== 1'b1 && cycles < 4 * latencyCycles) begin
        @(posedge clk);
        #2;
        cycles++;
        // inputs move once the sample is captured
        if (scramble) begin
            y = $random(seed);
            v = $random(seed);
        end
    end
    if (ack !== 1'b1) begin
        failRun("ack never rose after the request was raised");
    end
    checkLatency(cycles, latencyCycles);
    modelUpdate(yIn, vIn);
    checkOutputs();
    // held req must not start a second update
    repeat (holdCycles) begin
        @(posedge clk);
        #2;
        checkFlag("ack", ack, 1'b1);
        checkOutputs();
        if (scramble) begin
            y = $random(seed);
            v = $random(seed);
        end
    end
    req = 1'b0;
    // first edge with req low drops ack
    @(posedge clk);
    #2;
    checkFlag("ack", ack, 1'b0);
    checkOutputs();
endtask

//////////////////////////////
// directed tests
//////////////////////////////

task automatic testAfterReset();
    checkFlag("ack", ack, 1'b0);
    checkOutputs();
endtask

task automatic testSingleSample();
    qWord_t ySample;
    qWord_t vSample;
    ySample = $random(seed);
    vSample = $random(seed);
    runSample(ySample, vSample, 0, 1'b0);
endtask

// state has to carry from one sample to the next
task automatic testRandomSequence();
    qWord_t ySample;
    qWord_t vSample;
    for (int i = 0; i < 20; i++) begin
        ySample = $random(seed);
        vSample = $random(seed);
        runSample(ySample, vSample, 0, 1'b0);
    end
endtask

task automatic testSaturation();
    // prediction is the negative theta2 so y minus prediction overflows
    runSample(wordMax, '0, 0, 1'b0);
    checkEstimate("err", dut.uPredictionError.err, modelErr);
    checkEstimate("err", dut.uPredictionError.err, wordMax);
    // large positive regressor gives a positive prediction
    runSample(wordMin, wordMax, 0, 1'b0);
    checkEstimate("err", dut.uPredictionError.err, modelErr);
    checkEstimate("err", dut.uPredictionError.err, wordMin);
    // large negative regressor gives a negative prediction
    runSample(wordMax, wordMin, 0, 1'b0);
    checkEstimate("err", dut.uPredictionError.err, modelErr);
    checkEstimate("err", dut.uPredictionError.err, wordMax);
endtask

task automatic testHandshake();
    qWord_t ySample;
    qWord_t vSample;
    ySample = $random(seed);
    vSample = $random(seed);
    runSample(ySample, vSample, 5, 1'b1);
    // long enough for a stray update during the hold to show up
    repeat (2 * latencyCycles) begin
        @(posedge clk);
        #2;
        checkFlag("ack", ack, 1'b0);
        checkOutputs();
    end
endtask

`endif

/* tbGradientEstimator.sv */
`timescale 1ns/10ps

module tbGradientEstimator
    import estimatorPkg::*;
();

    // gains and initial estimates handed to the DUT
    localparam qWord_t thetaInitA = 32'h00466666;
    localparam qWord_t thetaInitB = 32'hF9800000;
    localparam qWord_t gainA      = 32'h00000001;
    localparam qWord_t gainB      = 32'h00000346;

    // edges from the accepting one through the one that raises ack
    localparam int latencyCycles = 11;
    localparam int clkPeriod     = 40;
    // one + twenty + three saturation + one handshake
    localparam int sampleCount   = 25;
    localparam int idleMargin    = 300;
    localparam int watchdogNs    = (sampleCount * latencyCycles + idleMargin) * clkPeriod * 2;

    logic   clk;
    logic   reset;
    logic   req;
    qWord_t y;
    qWord_t v;
    logic   ack;
    qWord_t theta1;
    qWord_t theta2;

    integer seed;

    gradientEstimator #(
        .thetaInitA (thetaInitA),
        .thetaInitB (thetaInitB),
        .gainA      (gainA),
        .gainB      (gainB)
    ) dut (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .y      (y),
        .v      (v),
        .ack    (ack),
        .theta1 (theta1),
        .theta2 (theta2)
    );

    always #(clkPeriod / 2) clk = ~clk;

    //////////////////////////////
    // failure and compare tasks
    //////////////////////////////

    task automatic failRun(string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // estimates and error words
    task automatic checkEstimate(string name, qWord_t actual, qWord_t expected);
        if (actual !== expected) begin
            failRun($sformatf("[FAIL] t=%0t %s: got %h, expected %h",
                              $time, name, actual, expected));
        end
    endtask

    // cycle counts
    task automatic checkLatency(int measured, int expected);
        if (measured != expected) begin
            failRun($sformatf("[FAIL] t=%0t ack latency: got %0d, expected %0d",
                              $time, measured, expected));
        end
    endtask

    // single handshake bits
    task automatic checkFlag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            failRun($sformatf("[FAIL] t=%0t %s: got %b, expected %b",
                              $time, name, actual, expected));
        end
    endtask

    `include "tbEstimatorTests.svh"

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        seed       = 40436;
        clk        = 1'b0;
        reset      = 1'b1;
        req        = 1'b0;
        y          = '0;
        v          = '0;
        fork
            begin
                #(watchdogNs);
                failRun($sformatf("timeout: the tests did not finish within %0d ns",
                                  watchdogNs));
            end
        join_none
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #2;
        testAfterReset();
        testSingleSample();
        testRandomSequence();
        testSaturation();
        testHandshake();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* gradientEstimator.f */
+incdir+.
estimatorPkg.sv
predictionError.sv
thetaUpdateLane.sv
estimateOutput.sv
gradientEstimator.sv
tbGradientEstimator.sv

/* runSim.sh */
#!/bin/sh
# build and run the gradient estimator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=simGradientEstimator

verilator --binary -f gradientEstimator.f --top-module tbGradientEstimator -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -qx "STATUS: PASS" "$LOG"; then
    echo "testbench passed"
    exit 0
fi
echo "testbench failed, see $LOG"
exit 1
